// File: logic/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // Rate of clk in MHz, all protocol timing derives from it
    localparam int unsigned CLK_MHZ = 250;

    // Flops on each incoming PS/2 line before it is used
    localparam int unsigned SYNC_STAGES = 2;

    // Host holds clock low for 100 us before the start bit
    localparam int unsigned RTS_HOLD_CYCLES = 100 * CLK_MHZ;

    // Device must finish the command frame within 15 ms
    localparam int unsigned TX_TIMEOUT_CYCLES = 15_000 * CLK_MHZ;

    localparam int unsigned HOLD_CNT_W = $clog2(RTS_HOLD_CYCLES);
    localparam int unsigned TIMEOUT_CNT_W = $clog2(TX_TIMEOUT_CYCLES + 1);

    typedef logic [7:0] ps2_byte_t;
    typedef logic [3:0] led_t;
    typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;
    typedef logic [TIMEOUT_CNT_W-1:0] timeout_cnt_t;

    // Byte codes seen on the bus
    localparam ps2_byte_t CMD_LED_ON = 8'h01;
    localparam ps2_byte_t CMD_LED_OFF = 8'h02;
    localparam ps2_byte_t DEV_ACK_BYTE = 8'hFA;

    // One received frame, valid is a single-cycle strobe
    typedef struct packed {
        ps2_byte_t data;
        logic      parity_err;
        logic      valid;
    } ps2_rx_frame_t;

    // Result of a command, read while cmd_ack is high
    typedef struct packed {
        logic timed_out;
        logic nack;
    } ps2_tx_status_t;

endpackage

`default_nettype wire

// File: logic/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_rx (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    ps2_clk_in,
    input  wire                    ps2_dat_in,
    input  wire                    tx_busy,
    output ps2_pkg::ps2_rx_frame_t rx_frame
);

    import ps2_pkg::*;

    typedef enum logic [1:0] {
        rx_idle,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    rx_state_t state;

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic clk_prev;
    logic clk_fall;
    logic dat_bit;

    ps2_byte_t shift_q;
    logic parity_q;
    logic [3:0] bit_cnt;
    logic parity_ok;

    ps2_byte_t frame_byte;
    logic frame_perr;
    logic frame_valid;

    // Lines idle high, so the synchronizer starts at ones
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], ps2_clk_in};
            dat_sync <= {dat_sync[SYNC_STAGES-2:0], ps2_dat_in};
            clk_prev <= clk_sync[SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[SYNC_STAGES-1];
    assign dat_bit = dat_sync[SYNC_STAGES-1];

    // Odd parity over data and parity bit
    assign parity_ok = ^{shift_q, parity_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rx_idle;
            bit_cnt <= 4'd0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (tx_busy) begin
                // Host owns the bus, drop whatever was in flight
                state <= rx_idle;
                bit_cnt <= 4'd0;
            end else if (clk_fall) begin
                case (state)
                    rx_idle: begin
                        // Start bit must be low
                        if (!dat_bit) begin
                            state <= rx_data;
                            bit_cnt <= 4'd0;
                        end
                    end
                    rx_data: begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd7) begin
                            state <= rx_parity;
                        end
                    end
                    rx_parity: state <= rx_stop;
                    rx_stop: begin
                        frame_valid <= 1'b1;
                        state <= rx_idle;
                    end
                    default: state <= rx_idle;
                endcase
            end
        end
    end

    // Data path, LSB first
    always_ff @(posedge clk) begin
        if (clk_fall && !tx_busy) begin
            if (state == rx_data) begin
                shift_q <= {dat_bit, shift_q[7:1]};
            end
            if (state == rx_parity) begin
                parity_q <= dat_bit;
            end
            if (state == rx_stop) begin
                frame_byte <= shift_q;
                // Low stop bit counts as a bad frame too
                frame_perr <= ~parity_ok | ~dat_bit;
            end
        end
    end

    assign rx_frame = '{data: frame_byte, parity_err: frame_perr, valid: frame_valid};

    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        rx_frame.valid |=> !rx_frame.valid);

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (reset)
        bit_cnt <= 4'd8);

endmodule

`default_nettype wire

// File: logic/ps2_tx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_tx (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      cmd_req,
    input  wire ps2_pkg::ps2_byte_t  cmd_byte,
    input  wire                      ps2_clk_in,
    input  wire                      ps2_dat_in,
    output logic                     cmd_ack,
    output ps2_pkg::ps2_tx_status_t  cmd_status,
    output logic                     ps2_clk_oe,
    output logic                     ps2_dat_oe,
    output logic                     tx_busy,
    output logic                     tx_done
);

    import ps2_pkg::*;

    typedef enum logic [2:0] {
        tx_idle,
        tx_request,
        tx_start,
        tx_shift,
        tx_parity,
        tx_stop,
        tx_dev_ack,
        tx_hs_ack
    } tx_state_t;

    tx_state_t state;

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic clk_prev;
    logic clk_fall;
    logic line_idle;
    logic line_phase;

    ps2_byte_t cmd_q;
    logic parity_q;
    logic [2:0] bit_idx;
    hold_cnt_t hold_cnt;
    timeout_cnt_t timeout_cnt;
    logic timeout_hit;

    logic clk_oe_q;
    logic dat_oe_q;
    logic ack_q;
    logic done_q;
    ps2_tx_status_t status_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], ps2_clk_in};
            dat_sync <= {dat_sync[SYNC_STAGES-2:0], ps2_dat_in};
            clk_prev <= clk_sync[SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[SYNC_STAGES-1];
    assign line_idle = clk_sync[SYNC_STAGES-1] & dat_sync[SYNC_STAGES-1];

    // States in which the device clocks the frame
    assign line_phase = state inside {tx_start, tx_shift, tx_parity, tx_stop, tx_dev_ack};
    assign timeout_hit = (timeout_cnt == timeout_cnt_t'(TX_TIMEOUT_CYCLES - 1));

    // Command byte and its odd parity, captured on request
    always_ff @(posedge clk) begin
        if (state == tx_idle && cmd_req) begin
            cmd_q <= cmd_byte;
            parity_q <= ~^cmd_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tx_idle;
            clk_oe_q <= 1'b0;
            dat_oe_q <= 1'b0;
            ack_q <= 1'b0;
            done_q <= 1'b0;
            status_q <= '0;
            bit_idx <= 3'd0;
            hold_cnt <= '0;
            timeout_cnt <= '0;
        end else begin
            done_q <= 1'b0;
            if (line_phase) begin
                timeout_cnt <= timeout_cnt + 1'b1;
            end
            if (line_phase && timeout_hit) begin
                // Device gave up or is absent, let go of the bus
                dat_oe_q <= 1'b0;
                status_q.timed_out <= 1'b1;
                ack_q <= 1'b1;
                done_q <= 1'b1;
                state <= tx_hs_ack;
            end else begin
                case (state)
                    tx_idle: begin
                        if (cmd_req) begin
                            clk_oe_q <= 1'b1;
                            hold_cnt <= '0;
                            status_q <= '0;
                            state <= tx_request;
                        end
                    end
                    tx_request: begin
                        hold_cnt <= hold_cnt + 1'b1;
                        if (hold_cnt == hold_cnt_t'(RTS_HOLD_CYCLES - 1)) begin
                            // Start bit low, then hand the clock to the device
                            clk_oe_q <= 1'b0;
                            dat_oe_q <= 1'b1;
                            timeout_cnt <= '0;
                            state <= tx_start;
                        end
                    end
                    tx_start: begin
                        if (clk_fall) begin
                            dat_oe_q <= ~cmd_q[0];
                            bit_idx <= 3'd0;
                            state <= tx_shift;
                        end
                    end
                    tx_shift: begin
                        if (clk_fall) begin
                            if (bit_idx == 3'd7) begin
                                dat_oe_q <= ~parity_q;
                                state <= tx_parity;
                            end else begin
                                dat_oe_q <= ~cmd_q[bit_idx + 3'd1];
                                bit_idx <= bit_idx + 3'd1;
                            end
                        end
                    end
                    tx_parity: begin
                        // Stop bit is the released line
                        if (clk_fall) begin
                            dat_oe_q <= 1'b0;
                            state <= tx_stop;
                        end
                    end
                    tx_stop: begin
                        // Eleventh falling edge carries the device ack bit
                        if (clk_fall) begin
                            status_q.nack <= dat_sync[SYNC_STAGES-1];
                            state <= tx_dev_ack;
                        end
                    end
                    tx_dev_ack: begin
                        if (line_idle) begin
                            ack_q <= 1'b1;
                            done_q <= 1'b1;
                            state <= tx_hs_ack;
                        end
                    end
                    tx_hs_ack: begin
                        if (!cmd_req) begin
                            ack_q <= 1'b0;
                            state <= tx_idle;
                        end
                    end
                    default: state <= tx_idle;
                endcase
            end
        end
    end

    assign cmd_ack = ack_q;
    assign cmd_status = status_q;
    assign ps2_clk_oe = clk_oe_q;
    assign ps2_dat_oe = dat_oe_q;
    assign tx_done = done_q;
    assign tx_busy = line_phase | (state == tx_request);

    a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_ack) |-> $past(cmd_req));

    a_no_dat_in_idle: assert property (@(posedge clk) disable iff (reset)
        (state == tx_idle) |-> !ps2_dat_oe);

    a_clk_oe_request: assert property (@(posedge clk) disable iff (reset)
        ps2_clk_oe |-> (state == tx_request));

endmodule

`default_nettype wire

// File: logic/key_led_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module key_led_ctrl (
    input  wire                            clk,
    input  wire                            reset,
    input  wire ps2_pkg::ps2_rx_frame_t    rx_frame,
    input  wire                            tx_done,
    input  wire ps2_pkg::ps2_tx_status_t   tx_status,
    output ps2_pkg::led_t                  led
);

    import ps2_pkg::*;

    led_t led_q;
    led_t led_next;
    logic good_frame;
    logic bad_frame;
    logic tx_failed;

    assign good_frame = rx_frame.valid & ~rx_frame.parity_err;
    assign bad_frame = rx_frame.valid & rx_frame.parity_err;
    assign tx_failed = tx_done & (tx_status.timed_out | tx_status.nack);

    always_comb begin
        led_next = led_q;

        // LED 0 and LED 1 react to clean frames only
        if (good_frame) begin
            case (rx_frame.data)
                CMD_LED_ON: led_next[0] = 1'b1;
                CMD_LED_OFF: led_next[0] = 1'b0;
                DEV_ACK_BYTE: led_next[1] = ~led_q[1];
                default: led_next = led_q;
            endcase
        end

        // Error flags hold until reset
        if (bad_frame) begin
            led_next[2] = 1'b1;
        end
        if (tx_failed) begin
            led_next[3] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            led_q <= '0;
        end else begin
            led_q <= led_next;
        end
    end

    assign led = led_q;

endmodule

`default_nettype wire

// File: logic/ps2_keyboard_top.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           ps2_clk_in,
    input  wire                           ps2_dat_in,
    output wire                           ps2_clk_oe,
    output wire                           ps2_dat_oe,
    input  wire                           cmd_req,
    input  wire ps2_pkg::ps2_byte_t       cmd_byte,
    output wire                           cmd_ack,
    output wire ps2_pkg::ps2_tx_status_t  cmd_status,
    output wire ps2_pkg::ps2_rx_frame_t   rx_frame,
    output wire ps2_pkg::led_t            led
);

    // Receiver stays off the lines while a command is on the bus
    wire tx_busy;
    wire tx_done;

    ps2_rx rx0 (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk_in (ps2_clk_in),
        .ps2_dat_in (ps2_dat_in),
        .tx_busy    (tx_busy),
        .rx_frame   (rx_frame)
    );

    ps2_tx tx0 (
        .clk        (clk),
        .reset      (reset),
        .cmd_req    (cmd_req),
        .cmd_byte   (cmd_byte),
        .ps2_clk_in (ps2_clk_in),
        .ps2_dat_in (ps2_dat_in),
        .cmd_ack    (cmd_ack),
        .cmd_status (cmd_status),
        .ps2_clk_oe (ps2_clk_oe),
        .ps2_dat_oe (ps2_dat_oe),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done)
    );

    key_led_ctrl led0 (
        .clk       (clk),
        .reset     (reset),
        .rx_frame  (rx_frame),
        .tx_done   (tx_done),
        .tx_status (cmd_status),
        .led       (led)
    );

endmodule

`default_nettype wire

// File: dv/ps2_device_model.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_device_model (
    input  wire                      clk,
    input  wire                      clk_oe,
    input  wire                      dat_oe,
    input  wire                      send_req,
    input  wire ps2_pkg::ps2_byte_t  send_byte,
    input  wire                      bad_parity,
    input  wire                      silent,
    output logic                     send_done,
    output wire                      clk_line,
    output wire                      dat_line,
    output ps2_pkg::ps2_byte_t       host_byte,
    output logic                     host_perr,
    output int                       host_cnt,
    output int                       rts_cycles
);

    import ps2_pkg::*;

    // Device clock half period in system cycles
    localparam int HALF = 40;

    logic dev_clk;
    logic dev_dat;
    int rts_count;

    // Open-drain lines, either side may pull low
    assign clk_line = dev_clk & ~clk_oe;
    assign dat_line = dev_dat & ~dat_oe;

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_frame(input ps2_byte_t b, input logic bad);
        logic [10:0] bits;
        bits = {1'b1, (~^b) ^ bad, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            dev_dat <= bits[i];
            wait_cycles(HALF / 2);
            dev_clk <= 1'b0;
            wait_cycles(HALF);
            dev_clk <= 1'b1;
            wait_cycles(HALF / 2);
        end
        dev_dat <= 1'b1;
    endtask

    // Host to device frame, data read on the rising clock edges
    task automatic receive_frame();
        logic [9:0] bits;
        wait_cycles(HALF / 2);
        for (int i = 0; i < 10; i++) begin
            dev_clk <= 1'b0;
            wait_cycles(HALF);
            dev_clk <= 1'b1;
            bits[i] = dat_line;
            wait_cycles(HALF);
        end
        host_byte <= bits[7:0];
        host_perr <= ~(^bits[8:0]) | ~bits[9];
        host_cnt <= host_cnt + 1;
        // Ack bit, low through the eleventh clock pulse
        dev_dat <= 1'b0;
        wait_cycles(HALF / 2);
        dev_clk <= 1'b0;
        wait_cycles(HALF);
        dev_clk <= 1'b1;
        wait_cycles(HALF / 2);
        dev_dat <= 1'b1;
    endtask

    initial begin
        dev_clk <= 1'b1;
        dev_dat <= 1'b1;
        send_done <= 1'b0;
        host_byte <= '0;
        host_perr <= 1'b0;
        host_cnt <= 0;
        rts_cycles <= 0;
        rts_count = 0;
        forever begin
            @(posedge clk);
            if (clk_oe) begin
                rts_count++;
            end else if (rts_count != 0) begin
                // Host released the clock, start bit should be on the data line
                rts_cycles <= rts_count;
                rts_count = 0;
                if (!silent && dat_oe) begin
                    receive_frame();
                end
            end else if (send_req && !send_done) begin
                send_frame(send_byte, bad_parity);
                send_done <= 1'b1;
            end else if (!send_req && send_done) begin
                send_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/ps2_kbd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_tb;

    import ps2_pkg::*;

    // Longest command wait covers a device that never answers
    localparam int CMD_WAIT = TX_TIMEOUT_CYCLES + RTS_HOLD_CYCLES + 2000;
    localparam int FRAME_WAIT = 4000;

    logic clk;
    logic reset;
    logic cmd_req;
    ps2_byte_t cmd_byte;
    wire cmd_ack;
    ps2_tx_status_t cmd_status;
    ps2_rx_frame_t rx_frame;
    led_t led;
    wire ps2_clk;
    wire ps2_dat;
    wire clk_oe;
    wire dat_oe;

    logic send_req;
    logic bad_parity;
    logic silent;
    logic send_done;
    ps2_byte_t send_byte;
    ps2_byte_t host_byte;
    logic host_perr;
    int host_cnt;
    int rts_cycles;

    ps2_byte_t exp_byte[$];
    logic exp_perr[$];
    ps2_tx_status_t exp_status = '0;
    led_t led_exp = '0;
    logic led_bad = 1'b0;
    logic ack_prev = 1'b0;
    int err_count = 0;
    int rx_count = 0;
    integer seed;

    ps2_keyboard_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk_in (ps2_clk),
        .ps2_dat_in (ps2_dat),
        .ps2_clk_oe (clk_oe),
        .ps2_dat_oe (dat_oe),
        .cmd_req    (cmd_req),
        .cmd_byte   (cmd_byte),
        .cmd_ack    (cmd_ack),
        .cmd_status (cmd_status),
        .rx_frame   (rx_frame),
        .led        (led)
    );

    ps2_device_model kbd0 (
        .clk        (clk),
        .clk_oe     (clk_oe),
        .dat_oe     (dat_oe),
        .send_req   (send_req),
        .send_byte  (send_byte),
        .bad_parity (bad_parity),
        .silent     (silent),
        .send_done  (send_done),
        .clk_line   (ps2_clk),
        .dat_line   (ps2_dat),
        .host_byte  (host_byte),
        .host_perr  (host_perr),
        .host_cnt   (host_cnt),
        .rts_cycles (rts_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Expected LEDs after one received frame or one finished command
    function automatic led_t led_model(input led_t cur, input logic is_rx,
                                       input ps2_byte_t data, input logic perr,
                                       input ps2_tx_status_t st);
        led_t nxt;
        nxt = cur;
        if (is_rx && perr) begin
            nxt[2] = 1'b1;
        end else if (is_rx) begin
            if (data == CMD_LED_ON) begin
                nxt[0] = 1'b1;
            end else if (data == CMD_LED_OFF) begin
                nxt[0] = 1'b0;
            end else if (data == DEV_ACK_BYTE) begin
                nxt[1] = !cur[1];
            end
        end else if (st.timed_out || st.nack) begin
            nxt[3] = 1'b1;
        end
        return nxt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // Frames and LEDs sampled mid-cycle
    always @(negedge clk) begin
        ps2_byte_t eb;
        logic ep;
        if (!reset) begin
            if (led !== led_exp) begin
                if (!led_bad) begin
                    $display("Error: led got 0x%0h expected 0x%0h", led, led_exp);
                    err_count++;
                end
                led_bad = 1'b1;
            end else begin
                led_bad = 1'b0;
            end
            if (rx_frame.valid) begin
                rx_count++;
                if (exp_byte.size() == 0) begin
                    $display("Frame 0x%0h received while none was sent", rx_frame.data);
                    err_count++;
                end else begin
                    eb = exp_byte.pop_front();
                    ep = exp_perr.pop_front();
                    check_value("rx_frame.data", rx_frame.data, eb);
                    check_value("rx_frame.parity_err", rx_frame.parity_err, ep);
                    led_exp = led_model(led_exp, 1'b1, eb, ep, '0);
                end
            end
            if (cmd_ack && !ack_prev) begin
                led_exp = led_model(led_exp, 1'b0, 8'h00, 1'b0, exp_status);
            end
            ack_prev = cmd_ack;
        end
    end

    task automatic device_send(input ps2_byte_t b, input logic bad);
        int wait_n;
        int target;
        target = rx_count + 1;
        exp_byte.push_back(b);
        exp_perr.push_back(bad);
        @(posedge clk);
        send_byte <= b;
        bad_parity <= bad;
        send_req <= 1'b1;
        wait_n = 0;
        while (!send_done && wait_n < FRAME_WAIT) begin
            @(negedge clk);
            wait_n++;
        end
        if (!send_done) begin
            $display("Device model never finished sending byte 0x%0h", b);
            err_count++;
        end
        @(posedge clk);
        send_req <= 1'b0;
        wait_n = 0;
        while ((send_done || rx_count < target) && wait_n < FRAME_WAIT) begin
            @(negedge clk);
            wait_n++;
        end
        if (rx_count < target) begin
            $display("No frame came out of the receiver for byte 0x%0h", b);
            err_count++;
        end
    endtask

    // Four-phase command handshake
    task automatic send_command(input ps2_byte_t b, input ps2_tx_status_t st_exp);
        int wait_n;
        exp_status = st_exp;
        @(posedge clk);
        cmd_byte <= b;
        cmd_req <= 1'b1;
        wait_n = 0;
        while (!cmd_ack && wait_n < CMD_WAIT) begin
            @(negedge clk);
            wait_n++;
        end
        if (!cmd_ack) begin
            $display("cmd_ack never rose for command 0x%0h", b);
            err_count++;
        end
        check_value("cmd_status", cmd_status, st_exp);
        // Ack has to stay up through a late drop of req
        repeat (3) @(negedge clk);
        if (!cmd_ack) begin
            $display("cmd_ack fell while cmd_req was still high");
            err_count++;
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        wait_n = 0;
        while (cmd_ack && wait_n < 20) begin
            @(negedge clk);
            wait_n++;
        end
        if (cmd_ack) begin
            $display("cmd_ack stayed high after cmd_req fell");
            err_count++;
        end
    endtask

    initial begin
        ps2_byte_t b;
        led_t led_before;
        int host_before;
        reset <= 1'b1;
        cmd_req <= 1'b0;
        cmd_byte <= '0;
        send_req <= 1'b0;
        send_byte <= '0;
        bad_parity <= 1'b0;
        silent <= 1'b0;
        seed = 91913;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (5) @(posedge clk);

        // LED 0 on, off and on again
        device_send(CMD_LED_ON, 1'b0);
        check_value("led[0]", led[0], 1'b1);
        device_send(CMD_LED_OFF, 1'b0);
        check_value("led[0]", led[0], 1'b0);
        device_send(CMD_LED_ON, 1'b0);
        check_value("led[0]", led[0], 1'b1);

        for (int i = 0; i < 30; i++) begin
            b = ps2_byte_t'($random(seed));
            device_send(b, 1'b0);
        end

        // Bad parity on a byte that would flip LED 0
        led_before = led_exp;
        b = led_before[0] ? CMD_LED_OFF : CMD_LED_ON;
        device_send(b, 1'b1);
        check_value("led[2]", led[2], 1'b1);
        check_value("led[0]", led[0], led_before[0]);

        host_before = host_cnt;
        send_command(8'hED, '0);
        check_value("host_cnt", host_cnt, host_before + 1);
        check_value("host_byte", host_byte, 8'hED);
        check_value("host_perr", host_perr, 1'b0);
        if (rts_cycles < RTS_HOLD_CYCLES) begin
            $display("Error: rts_cycles got 0x%0h expected at least 0x%0h",
                     rts_cycles, RTS_HOLD_CYCLES);
            err_count++;
        end
        led_before = led_exp;
        device_send(DEV_ACK_BYTE, 1'b0);
        check_value("led[1]", led[1], !led_before[1]);

        // Device stays silent through a whole command
        @(posedge clk);
        silent <= 1'b1;
        send_command(8'hF4, '{timed_out: 1'b1, nack: 1'b0});
        check_value("led[3]", led[3], 1'b1);
        check_value("ps2_clk_oe", clk_oe, 1'b0);
        check_value("ps2_dat_oe", dat_oe, 1'b0);
        @(posedge clk);
        silent <= 1'b0;
        b = ps2_byte_t'($random(seed));
        device_send(b, 1'b0);
        check_value("led[2]", led[2], 1'b1);

        repeat (10) @(posedge clk);
        if (exp_byte.size() != 0) begin
            $display("%0d sent frames never reached rx_frame", exp_byte.size());
            err_count++;
        end
        $display("Frames checked: %0d, errors: %0d", rx_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/ps2_pkg.sv
logic/ps2_rx.sv
logic/ps2_tx.sv
logic/key_led_ctrl.sv
logic/ps2_keyboard_top.sv
dv/ps2_device_model.sv
dv/ps2_kbd_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = ps2_kbd_tb
FILELIST  = build.f
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
